// File: tetris_pkg.sv
// shared playfield sizes, key codes, gravity timing and types for the piece controller
package tetris_pkg;

    // ------------------------------
    // playfield geometry
    // ------------------------------
    // 10 x 22 field, row 0 at the top
    localparam int FIELD_W    = 10;
    localparam int FIELD_H    = 22;
    localparam int CELL_COUNT = FIELD_W * FIELD_H;

    // only the 2x2 square piece
    localparam int PIECE_SIZE  = 2;
    localparam int PIECE_CELLS = PIECE_SIZE * PIECE_SIZE;

    // top-left cell of a fresh piece
    localparam int SPAWN_X = 4;
    localparam int SPAWN_Y = 0;

    // ------------------------------
    // timing
    // ------------------------------
    // cycles between gravity steps
    localparam int GRAVITY_PERIOD = 8;
    localparam int GRAVITY_CNT_W  = $clog2(GRAVITY_PERIOD);

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [3:0]              col_t;
    typedef logic [4:0]              row_t;
    // row * FIELD_W + column
    typedef logic [7:0]              cell_idx_t;
    typedef logic [7:0]              keycode_t;
    typedef logic [CELL_COUNT-1:0]   field_t;
    typedef cell_idx_t [PIECE_CELLS-1:0] piece_cells_t;
    typedef logic [GRAVITY_CNT_W-1:0] gravity_cnt_t;

    // usb hid arrow keys
    localparam keycode_t KEY_LEFT  = 8'h50;
    localparam keycode_t KEY_RIGHT = 8'h4F;
    localparam keycode_t KEY_DROP  = 8'h51;

endpackage

// File: lock_if.sv
// lock request channel from the piece FSM to the field store, four-phase req/ack
`timescale 1ns/1ps

interface lock_if;

    // controller asks for a write
    logic                     req;
    // store has written the cells
    logic                     ack;
    // cells of the landed piece, held while req is up
    tetris_pkg::piece_cells_t cells;

    // piece FSM side
    modport ctrl (
        output req,
        output cells,
        input  ack
    );

    // field store side
    modport store (
        input  req,
        input  cells,
        output ack
    );

endinterface

// File: fall_timer.sv
// gravity timer, one tick per gravity period while the piece is in play
`timescale 1ns/1ps

module fall_timer (
    input  logic frame_clk,
    input  logic Reset,
    input  logic run,
    input  logic restart,
    output logic tick
);

    tetris_pkg::gravity_cnt_t count;
    logic                     at_end;

    // last count of the period
    assign at_end = count == tetris_pkg::gravity_cnt_t'(tetris_pkg::GRAVITY_PERIOD - 1);

    // tick only on a counting cycle
    assign tick = run && at_end;

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            count <= '0;
        end else if (restart) begin
            // new piece gets a full period
            count <= '0;
        end else if (run) begin
            if (at_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
        // run low, hold the count
    end

endmodule

// File: piece_geometry.sv
// cell indices of the square piece at a candidate spot, and the wall/floor/stack test
`timescale 1ns/1ps

module piece_geometry (
    input  tetris_pkg::col_t         cand_x,
    input  tetris_pkg::row_t         cand_y,
    input  tetris_pkg::field_t       field,
    output tetris_pkg::piece_cells_t cells,
    output logic                     blocked
);

    // index of the top-left cell, wide enough for any candidate
    logic [8:0] base;
    logic       in_bounds;
    logic       occupied;

    assign base = 9'(cand_y) * 9'(tetris_pkg::FIELD_W) + 9'(cand_x);

    // piece must sit fully inside the field
    assign in_bounds =
        (cand_x <= tetris_pkg::col_t'(tetris_pkg::FIELD_W - tetris_pkg::PIECE_SIZE)) &&
        (cand_y <= tetris_pkg::row_t'(tetris_pkg::FIELD_H - tetris_pkg::PIECE_SIZE));

    // ------------------------------
    // cell list, row major
    // ------------------------------
    always_comb begin
        for (int r = 0; r < tetris_pkg::PIECE_SIZE; r++) begin
            for (int c = 0; c < tetris_pkg::PIECE_SIZE; c++) begin
                cells[r * tetris_pkg::PIECE_SIZE + c] =
                    tetris_pkg::cell_idx_t'(base + 9'(r * tetris_pkg::FIELD_W + c));
            end
        end
    end

    // ------------------------------
    // overlap with the stack
    // ------------------------------
    always_comb begin
        occupied = 1'b0;
        // indices are garbage outside the field, skip them
        if (in_bounds) begin
            for (int i = 0; i < tetris_pkg::PIECE_CELLS; i++) begin
                if (field[cells[i]]) begin
                    occupied = 1'b1;
                end
            end
        end
    end

    // left wall shows up as a wrap to column 15
    assign blocked = !in_bounds || occupied;

endmodule

// File: field_store.sv
// occupancy register of the 220-cell playfield, written through the lock handshake
`timescale 1ns/1ps

module field_store (
    input  logic               frame_clk,
    input  logic               Reset,
    lock_if.store              lk,
    output tetris_pkg::field_t field
);

    // bits to set for the current request
    tetris_pkg::field_t set_mask;

    always_comb begin
        set_mask = '0;
        for (int i = 0; i < tetris_pkg::PIECE_CELLS; i++) begin
            set_mask[lk.cells[i]] = 1'b1;
        end
    end

    // ------------------------------
    // four-phase responder
    // ------------------------------
    // req up, ack low  : write once, raise ack
    // req down, ack up : drop ack
    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            field  <= '0;
            lk.ack <= 1'b0;
        end else begin
            if (lk.req && !lk.ack) begin
                // cells only ever get set
                field  <= field | set_mask;
                lk.ack <= 1'b1;
            end else if (!lk.req && lk.ack) begin
                lk.ack <= 1'b0;
            end
        end
    end

endmodule

// File: piece_ctrl_fsm.sv
// piece FSM: position, key presses, gravity and drop moves, lock sequence, game over
`timescale 1ns/1ps

module piece_ctrl_fsm (
    input  logic                     frame_clk,
    input  logic                     Reset,
    input  tetris_pkg::keycode_t     keycode,
    input  logic                     tick,
    input  logic                     blocked,
    input  tetris_pkg::piece_cells_t cells,
    output tetris_pkg::col_t         cand_x,
    output tetris_pkg::row_t         cand_y,
    output tetris_pkg::col_t         piece_x,
    output tetris_pkg::row_t         piece_y,
    output logic                     run,
    output logic                     restart,
    lock_if.ctrl                     lk,
    output logic                     piece_locked,
    output logic                     game_over
);

    typedef enum logic [2:0] {
        ST_PLAY,
        ST_DROP,
        ST_LOCK_REQ,
        ST_LOCK_REL,
        ST_OVER
    } state_t;

    state_t               state;
    // last cycle's key, for edge detect
    tetris_pkg::keycode_t prev_key;
    // one deferred side move
    logic                 pend_valid;
    logic                 pend_left;

    logic key_press;
    logic h_press;
    logic h_left;
    logic drop_press;
    logic h_valid;
    logic go_left;
    logic move_down;
    logic move_side;

    // ------------------------------
    // key decode
    // ------------------------------
    assign key_press  = keycode != prev_key;
    assign h_left     = keycode == tetris_pkg::KEY_LEFT;
    assign h_press    = key_press && (h_left || keycode == tetris_pkg::KEY_RIGHT);
    assign drop_press = key_press && keycode == tetris_pkg::KEY_DROP;

    // pending move goes first
    assign h_valid = pend_valid || h_press;
    assign go_left = pend_valid ? pend_left : h_left;

    // tick beats a side move, drop mode ignores side keys
    assign move_down = (state == ST_PLAY && tick) || state == ST_DROP;
    assign move_side = state == ST_PLAY && !tick && h_valid;

    // ------------------------------
    // candidate position
    // ------------------------------
    always_comb begin
        // current spot while locking or idle
        cand_x = piece_x;
        cand_y = piece_y;
        if (move_down) begin
            cand_y = piece_y + 1'b1;
        end else if (move_side) begin
            // 0 - 1 wraps high, geometry sees it as outside
            cand_x = go_left ? piece_x - 1'b1 : piece_x + 1'b1;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    // gravity counts only in normal play
    assign run     = state == ST_PLAY;
    assign restart = state == ST_LOCK_REL && !lk.ack;

    // candidate equals the piece in lock states, so cells hold steady
    assign lk.req   = state == ST_LOCK_REQ;
    assign lk.cells = cells;

    // first ack cycle, field already shows the piece
    assign piece_locked = state == ST_LOCK_REQ && lk.ack;
    assign game_over    = state == ST_OVER;

    always_ff @(posedge frame_clk or posedge Reset) begin
        if (Reset) begin
            state      <= ST_PLAY;
            piece_x    <= tetris_pkg::col_t'(tetris_pkg::SPAWN_X);
            piece_y    <= tetris_pkg::row_t'(tetris_pkg::SPAWN_Y);
            prev_key   <= '0;
            pend_valid <= 1'b0;
            pend_left  <= 1'b0;
        end else begin
            prev_key <= keycode;
            case (state)
                ST_PLAY: begin
                    if ((move_down || move_side) && !blocked) begin
                        piece_x <= cand_x;
                        piece_y <= cand_y;
                    end
                    // landed on a gravity step
                    if (tick && blocked) begin
                        state      <= ST_LOCK_REQ;
                        pend_valid <= 1'b0;
                    end else if (drop_press) begin
                        state      <= ST_DROP;
                        pend_valid <= 1'b0;
                    end else if (tick) begin
                        // side move waits one cycle
                        pend_valid <= h_valid;
                        if (h_press) begin
                            pend_left <= h_left;
                        end
                    end else begin
                        // pending served, a fresh press takes its slot
                        pend_valid <= pend_valid && h_press;
                        pend_left  <= h_left;
                    end
                end
                ST_DROP: begin
                    // one row per cycle until blocked
                    if (blocked) begin
                        state <= ST_LOCK_REQ;
                    end else begin
                        piece_y <= cand_y;
                    end
                end
                ST_LOCK_REQ: begin
                    if (lk.ack) begin
                        state <= ST_LOCK_REL;
                    end
                end
                ST_LOCK_REL: begin
                    // wait for ack to fall, then respawn or stop
                    if (!lk.ack) begin
                        if (piece_y == '0) begin
                            state <= ST_OVER;
                        end else begin
                            state   <= ST_PLAY;
                            piece_x <= tetris_pkg::col_t'(tetris_pkg::SPAWN_X);
                            piece_y <= tetris_pkg::row_t'(tetris_pkg::SPAWN_Y);
                        end
                    end
                end
                ST_OVER: begin
                    // frozen until reset
                    state <= ST_OVER;
                end
                default: begin
                    state <= ST_PLAY;
                end
            endcase
            if (state != ST_PLAY) begin
                pend_valid <= 1'b0;
            end
        end
    end

endmodule

// File: tetris_core.sv
// top level of the falling-piece controller, FSM plus timer, geometry and field store
`timescale 1ns/1ps

module tetris_core (
    input  logic                 frame_clk,
    input  logic                 Reset,
    input  tetris_pkg::keycode_t keycode,
    output tetris_pkg::col_t     piece_x,
    output tetris_pkg::row_t     piece_y,
    output tetris_pkg::field_t   field,
    output logic                 piece_locked,
    output logic                 game_over
);

    // ------------------------------
    // internal nets
    // ------------------------------
    tetris_pkg::col_t         cand_x;
    tetris_pkg::row_t         cand_y;
    tetris_pkg::piece_cells_t cand_cells;
    logic                     blocked;
    logic                     run;
    logic                     restart;
    logic                     tick;

    // lock write channel
    lock_if lock_bus ();

    piece_ctrl_fsm piece_ctrl_fsm_inst (
        .frame_clk    (frame_clk),
        .Reset        (Reset),
        .keycode      (keycode),
        .tick         (tick),
        .blocked      (blocked),
        .cells        (cand_cells),
        .cand_x       (cand_x),
        .cand_y       (cand_y),
        .piece_x      (piece_x),
        .piece_y      (piece_y),
        .run          (run),
        .restart      (restart),
        .lk           (lock_bus.ctrl),
        .piece_locked (piece_locked),
        .game_over    (game_over)
    );

    // gravity
    fall_timer fall_timer_inst (
        .frame_clk (frame_clk),
        .Reset     (Reset),
        .run       (run),
        .restart   (restart),
        .tick      (tick)
    );

    // walls, floor and stack test
    piece_geometry piece_geometry_inst (
        .cand_x  (cand_x),
        .cand_y  (cand_y),
        .field   (field),
        .cells   (cand_cells),
        .blocked (blocked)
    );

    field_store field_store_inst (
        .frame_clk (frame_clk),
        .Reset     (Reset),
        .lk        (lock_bus.store),
        .field     (field)
    );

endmodule

// File: tetris_core_sva.sv
// concurrent assertions on the lock handshake, piece bounds and game over
`timescale 1ns/1ps

module tetris_core_sva (
    input logic                     frame_clk,
    input logic                     Reset,
    input logic                     req,
    input logic                     ack,
    input tetris_pkg::piece_cells_t cells,
    input tetris_pkg::col_t         piece_x,
    input tetris_pkg::row_t         piece_y,
    input logic                     game_over
);

    // ------------------------------
    // four-phase order
    // ------------------------------
    a_req_rise: assert property (@(posedge frame_clk) disable iff (Reset)
        $rose(req) |-> !ack) else $error("lock req rose while ack high");

    a_ack_rise: assert property (@(posedge frame_clk) disable iff (Reset)
        $rose(ack) |-> req) else $error("lock ack rose without req");

    a_req_fall: assert property (@(posedge frame_clk) disable iff (Reset)
        $fell(req) |-> ack) else $error("lock req fell before ack");

    a_ack_fall: assert property (@(posedge frame_clk) disable iff (Reset)
        $fell(ack) |-> !req) else $error("lock ack fell while req high");

    // cells held for the whole request
    a_cells_stable: assert property (@(posedge frame_clk) disable iff (Reset)
        req && $past(req) |-> $stable(cells)) else $error("lock cells changed under req");

    // ------------------------------
    // piece bounds and game over
    // ------------------------------
    a_x_bound: assert property (@(posedge frame_clk) disable iff (Reset)
        int'(piece_x) <= tetris_pkg::FIELD_W - tetris_pkg::PIECE_SIZE)
        else $error("piece_x past right wall");

    a_y_bound: assert property (@(posedge frame_clk) disable iff (Reset)
        int'(piece_y) <= tetris_pkg::FIELD_H - tetris_pkg::PIECE_SIZE)
        else $error("piece_y past floor");

    a_over_sticky: assert property (@(posedge frame_clk) disable iff (Reset)
        game_over |=> game_over) else $error("game_over fell before reset");

endmodule

bind tetris_core tetris_core_sva tetris_core_sva_inst (
    .frame_clk (frame_clk),
    .Reset     (Reset),
    .req       (lock_bus.req),
    .ack       (lock_bus.ack),
    .cells     (lock_bus.cells),
    .piece_x   (piece_x),
    .piece_y   (piece_y),
    .game_over (game_over)
);

// File: tb_tetris_core.sv
// testbench for the falling-piece controller with random keys and a model of field and moves
`timescale 1ns/1ps

module tb_tetris_core;

    localparam int CYCLE_LIMIT = 40000;
    localparam int MAX_X       = tetris_pkg::FIELD_W - tetris_pkg::PIECE_SIZE;
    localparam int MAX_Y       = tetris_pkg::FIELD_H - tetris_pkg::PIECE_SIZE;

    logic                 frame_clk;
    logic                 Reset;
    tetris_pkg::keycode_t keycode;
    tetris_pkg::col_t     piece_x;
    tetris_pkg::row_t     piece_y;
    tetris_pkg::field_t   field;
    logic                 piece_locked;
    logic                 game_over;

    int          errors;
    int          checks;
    int          cycle_count;
    int unsigned seed_val;

    // reference model state
    tetris_pkg::field_t model_field;
    int                 spawn_wait;
    int                 lock_row;
    logic               frozen;
    int                 frz_x;
    int                 frz_y;
    tetris_pkg::field_t frz_field;

    tetris_core tetris_core_inst (
        .frame_clk    (frame_clk),
        .Reset        (Reset),
        .keycode      (keycode),
        .piece_x      (piece_x),
        .piece_y      (piece_y),
        .field        (field),
        .piece_locked (piece_locked),
        .game_over    (game_over)
    );

    initial begin
        frame_clk = 1'b0;
        forever #20 frame_clk = ~frame_clk;
    end

    // ------------------------------
    // check helpers
    // ------------------------------
    task automatic check_int(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_field(input tetris_pkg::field_t expected,
                               input tetris_pkg::field_t actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED t=%0t field expected %0h actual %0h", $time, expected, actual);
        end
    endtask

    task automatic check_cond(input string what, input logic cond);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR t=%0t %s", $time, what);
        end
    endtask

    // four cells of a square with top-left at x, y
    function automatic tetris_pkg::field_t square_mask(input int x, input int y);
        tetris_pkg::field_t m;
        m = '0;
        for (int r = 0; r < tetris_pkg::PIECE_SIZE; r++) begin
            for (int c = 0; c < tetris_pkg::PIECE_SIZE; c++) begin
                m[(y + r) * tetris_pkg::FIELD_W + x + c] = 1'b1;
            end
        end
        return m;
    endfunction

    // floor or stack right under the square
    function automatic logic rests_on(input int x, input int y, input tetris_pkg::field_t f);
        int below;
        if (y >= MAX_Y) begin
            return 1'b1;
        end
        below = (y + tetris_pkg::PIECE_SIZE) * tetris_pkg::FIELD_W + x;
        return f[below] || f[below + 1];
    endfunction

    // ------------------------------
    // model and monitor sampled mid-cycle
    // ------------------------------
    always @(negedge frame_clk) begin
        if (Reset) begin
            model_field = '0;
            spawn_wait  = 0;
            frozen      = 1'b0;
        end else begin
            if (piece_locked) begin
                // single-cycle pulse, no second lock before the respawn
                check_cond("piece_locked high again before the piece respawned",
                           spawn_wait == 0);
                check_cond("piece locked while not resting on floor or stack",
                           rests_on(int'(piece_x), int'(piece_y), model_field));
                model_field = model_field | square_mask(int'(piece_x), int'(piece_y));
                lock_row    = int'(piece_y);
                // req rose one cycle earlier so respawn is 3 cycles away
                spawn_wait  = 3;
            end else if (spawn_wait > 0) begin
                spawn_wait--;
                if (spawn_wait == 0) begin
                    if (lock_row == 0) begin
                        check_int("game_over", 1, int'(game_over));
                    end else begin
                        check_int("piece_x", tetris_pkg::SPAWN_X, int'(piece_x));
                        check_int("piece_y", tetris_pkg::SPAWN_Y, int'(piece_y));
                    end
                end
            end
            check_field(model_field, field);
            if (frozen) begin
                check_int("piece_x", frz_x, int'(piece_x));
                check_int("piece_y", frz_y, int'(piece_y));
                check_field(frz_field, field);
            end else if (game_over) begin
                frozen    = 1'b1;
                frz_x     = int'(piece_x);
                frz_y     = int'(piece_y);
                frz_field = field;
            end
        end
    end

    // ------------------------------
    // stimulus tasks
    // ------------------------------
    // one side press and release with the result due within two cycles
    task automatic side_press(input logic left);
        int x0;
        int exp_x;
        x0 = int'(piece_x);
        if (left) begin
            exp_x = (x0 > 0) ? x0 - 1 : x0;
        end else begin
            exp_x = (x0 < MAX_X) ? x0 + 1 : x0;
        end
        @(posedge frame_clk);
        keycode <= left ? tetris_pkg::KEY_LEFT : tetris_pkg::KEY_RIGHT;
        @(posedge frame_clk);
        keycode <= 8'h00;
        @(posedge frame_clk);
        @(negedge frame_clk);
        check_int("piece_x", exp_x, int'(piece_x));
    endtask

    // rows step once per gravity period with keys idle
    task automatic gravity_fall();
        int   last_y;
        int   gap;
        logic seen;
        @(posedge frame_clk);
        keycode <= 8'h00;
        @(negedge frame_clk);
        last_y = int'(piece_y);
        gap    = 0;
        seen   = 1'b0;
        while (!piece_locked) begin
            @(negedge frame_clk);
            gap++;
            if (int'(piece_y) != last_y) begin
                check_int("piece_y", last_y + 1, int'(piece_y));
                if (seen) begin
                    check_int("gravity_gap", tetris_pkg::GRAVITY_PERIOD, gap);
                end
                seen   = 1'b1;
                gap    = 0;
                last_y = int'(piece_y);
            end
        end
    endtask

    // drop press moves one row per cycle until landed
    task automatic drop_fall();
        int   last_y;
        logic moving;
        logic stalled;
        @(posedge frame_clk);
        keycode <= 8'h00;
        @(posedge frame_clk);
        keycode <= tetris_pkg::KEY_DROP;
        @(negedge frame_clk);
        last_y  = int'(piece_y);
        moving  = 1'b0;
        stalled = 1'b0;
        while (!piece_locked) begin
            @(negedge frame_clk);
            if (int'(piece_y) != last_y) begin
                check_int("piece_y", last_y + 1, int'(piece_y));
                check_cond("drop moved again after stopping", !stalled);
                moving = 1'b1;
                last_y = int'(piece_y);
            end else if (moving && !stalled) begin
                stalled = 1'b1;
                check_cond("drop stopped before landing",
                           rests_on(int'(piece_x), int'(piece_y), model_field));
            end
        end
    endtask

    // ------------------------------
    // timeout
    // ------------------------------
    always @(posedge frame_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        seed_val    = $urandom(32'hfbf8_ce43);
        Reset       = 1'b1;
        keycode     = 8'h00;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        repeat (5) @(posedge frame_clk);
        Reset <= 1'b0;
        @(negedge frame_clk);
        // state right after reset
        check_int("piece_x", tetris_pkg::SPAWN_X, int'(piece_x));
        check_int("piece_y", tetris_pkg::SPAWN_Y, int'(piece_y));
        check_field('0, field);
        check_int("piece_locked", 0, int'(piece_locked));
        check_int("game_over", 0, int'(game_over));

        for (int p = 0; p < 10; p++) begin
            // side moves only while the top half is empty
            if (field[99:0] == '0) begin
                repeat ($urandom_range(9, 0)) begin
                    side_press(1'($urandom_range(1, 0)));
                    repeat ($urandom_range(2, 0)) @(negedge frame_clk);
                end
            end
            if ($urandom_range(1, 0) == 1) begin
                gravity_fall();
            end else begin
                drop_fall();
            end
            repeat (3) @(negedge frame_clk);
        end

        // stack at the spawn column up to row 0
        while (!game_over) begin
            drop_fall();
            repeat (3) @(negedge frame_clk);
        end

        // keys after game over change nothing
        repeat (60) begin
            @(posedge frame_clk);
            case ($urandom_range(3, 0))
                0: keycode <= tetris_pkg::KEY_LEFT;
                1: keycode <= tetris_pkg::KEY_RIGHT;
                2: keycode <= tetris_pkg::KEY_DROP;
                default: keycode <= 8'($urandom_range(255, 0));
            endcase
        end
        @(negedge frame_clk);

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
tetris_pkg.sv
lock_if.sv
fall_timer.sv
piece_geometry.sv
field_store.sv
piece_ctrl_fsm.sv
tetris_core.sv
tetris_core_sva.sv
tb_tetris_core.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_tetris_core -o sim_tetris

out=$(./obj_dir/sim_tetris 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
